//--- sim/tb_clock.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock (10 ns) and reset. Reset is held for 4 cycles at start
// and again after each cycle in which restart is high.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_clock
(
	input logic restart,
	output logic clk,
	output logic reset
);

	logic [2:0] hold;

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		hold = 3'd0;
	end

	always #5 clk = ~clk;

	always @(posedge clk)
	begin
		if (restart)
		begin
			reset <= 1'b1;
			hold <= 3'd0;
		end
		else if (hold == 3'd3)
			reset <= 1'b0;
		else
			hold <= hold + 3'd1;
	end

endmodule

//--- sim/tb_f8_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the f8 core. Runs random programs from two bank models
// and compares every memory write against an instruction-level model.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "f8_defines.svh"

module tb_f8_core import f8_pkg::*;
();

	logic clk;
	logic reset;
	logic restart;
	bank_addr_t even_rd_addr;
	bank_addr_t odd_rd_addr;
	byte_t even_rd_data;
	byte_t odd_rd_data;
	bank_wr_t even_wr;
	bank_wr_t odd_wr;
	logic trap;

	byte_t even_bank [0:32767];
	byte_t odd_bank [0:32767];
	// flat copy of memory that the model also runs on
	byte_t image [0:65535];
	logic [23:0] exp_writes [$];
	integer seed;
	word_t gen_pc;
	word_t even_byte;
	word_t odd_byte;
	logic checking;
	logic armed;
	int cycles_left;

	tb_clock i_tb_clock
	(
		.restart(restart),
		.clk(clk),
		.reset(reset)
	);

	f8_core i_f8_core
	(
		.clk(clk),
		.reset(reset),
		.even_rd_addr(even_rd_addr),
		.even_rd_data(even_rd_data),
		.even_wr(even_wr),
		.odd_rd_addr(odd_rd_addr),
		.odd_rd_data(odd_rd_data),
		.odd_wr(odd_wr),
		.trap(trap)
	);

	// bank RAMs with one cycle of read latency
	always @(posedge clk)
	begin
		even_rd_data <= even_bank[even_rd_addr];
		odd_rd_data <= odd_bank[odd_rd_addr];
		if (even_wr.en)
			even_bank[even_wr.addr] <= even_wr.data;
		if (odd_wr.en)
			odd_bank[odd_wr.addr] <= odd_wr.data;
	end

	task automatic fail_run(string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(string what, logic [31:0] got, logic [31:0] exp);
		if (got !== exp)
			fail_run($sformatf("ERR %0d ns: %s is %0h, expected %0h", $time, what, got, exp));
	endtask

	function automatic byte_t random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	function automatic word_t data_addr();
		return {8'h80, random_byte()};
	endfunction

	function automatic opcode_t pick_alu_op(int k);
		case (k)
			0: return OP_LD_XL_IMMD;
			1: return OP_ADD_XL_IMMD;
			2: return OP_SUB_XL_IMMD;
			3: return OP_AND_XL_IMMD;
			4: return OP_OR_XL_IMMD;
			default: return OP_XOR_XL_IMMD;
		endcase
	endfunction

	function automatic opcode_t pick_jump_op(int k);
		case (k)
			0: return OP_JR_D;
			1: return OP_JRZ_D;
			2: return OP_JRNZ_D;
			default: return OP_JRC_D;
		endcase
	endfunction

	task automatic put_byte(word_t a, byte_t v);
		image[a] = v;
		if (a[0])
			odd_bank[a[15:1]] = v;
		else
			even_bank[a[15:1]] = v;
	endtask

	task automatic emit(byte_t b);
		put_byte(gen_pc, b);
		gen_pc = gen_pc + 16'd1;
	endtask

	task automatic emit_word(byte_t op, word_t w);
		emit(op);
		emit(w[7:0]);
		emit(w[15:8]);
	endtask

	task automatic build_program();
		int kind;
		for (int a = 0; a < 512; a++)
			put_byte(16'h8000 + a[15:0], random_byte());
		gen_pc = `F8_RESET_PC;
		emit(OP_LD_XL_IMMD);
		emit(random_byte());
		emit_word(OP_LDW_Y_IMMD, {random_byte(), random_byte()});
		for (int i = 0; i < 30; i++)
		begin
			kind = random_byte() % 8;
			case (kind)
				0, 1:
				begin
					emit(pick_alu_op(random_byte() % 6));
					// zero now and then so the z flag gets exercised
					emit(random_byte() < 8'd40 ? 8'h00 : random_byte());
				end
				2: emit_word(OP_LD_DIR_XL, data_addr());
				3: emit_word(OP_LDW_Y_IMMD, {random_byte(), random_byte()});
				4: emit_word(OP_LDW_DIR_Y, data_addr());
				5: emit_word(OP_LD_XL_DIR, data_addr());
				6:
				begin
					// displacement 5 skips the 3-byte guard store
					emit(pick_jump_op(random_byte() % 4));
					emit(8'd5);
					emit_word(random_byte() < 8'd128 ? OP_LD_DIR_XL : OP_LDW_DIR_Y, data_addr());
				end
				default: emit(OP_NOP);
			endcase
		end
		emit(OP_TRAP);
	endtask

	task automatic store_byte(word_t a, byte_t v);
		image[a] = v;
		exp_writes.push_back({a, v});
	endtask

	task automatic run_model(output int steps);
		word_t pc;
		word_t dir;
		word_t y;
		word_t len;
		byte_t xl;
		byte_t imm;
		logic [8:0] sum;
		logic z;
		logic c;
		logic taken;
		opcode_t op;
		exp_writes.delete();
		steps = 0;
		pc = `F8_RESET_PC;
		xl = 8'h00;
		y = 16'h0000;
		z = 1'b0;
		c = 1'b0;
		op = opcode_t'(image[pc]);
		while (op != OP_TRAP)
		begin
			dir = {image[pc + 16'd2], image[pc + 16'd1]};
			imm = dir[7:0];
			taken = 1'b0;
			len = 16'd2;
			case (op)
				OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD,
				OP_OR_XL_IMMD, OP_XOR_XL_IMMD, OP_LD_XL_DIR:
				begin
					if (op == OP_LD_XL_DIR)
					begin
						imm = image[dir];
						len = 16'd3;
					end
					sum = {1'b0, xl} + {1'b0, imm};
					// carry on subtract means no borrow
					if (op == OP_ADD_XL_IMMD)
						c = sum[8];
					else if (op == OP_SUB_XL_IMMD)
						c = xl >= imm;
					case (op)
						OP_ADD_XL_IMMD: xl = sum[7:0];
						OP_SUB_XL_IMMD: xl = xl - imm;
						OP_AND_XL_IMMD: xl = xl & imm;
						OP_OR_XL_IMMD: xl = xl | imm;
						OP_XOR_XL_IMMD: xl = xl ^ imm;
						default: xl = imm;
					endcase
					z = xl == 8'h00;
				end
				OP_LD_DIR_XL:
				begin
					store_byte(dir, xl);
					len = 16'd3;
				end
				OP_LDW_Y_IMMD:
				begin
					y = dir;
					len = 16'd3;
				end
				OP_LDW_DIR_Y:
				begin
					store_byte(dir, y[7:0]);
					store_byte(dir + 16'd1, y[15:8]);
					len = 16'd3;
				end
				OP_JR_D: taken = 1'b1;
				OP_JRZ_D: taken = z;
				OP_JRNZ_D: taken = !z;
				OP_JRC_D: taken = c;
				OP_NOP: len = 16'd1;
				default: fail_run("reference model met an unknown opcode");
			endcase
			pc = taken ? pc + {{8{imm[7]}}, imm} : pc + len;
			steps++;
			if (steps > 500)
				fail_run("reference model did not reach a trap");
			op = opcode_t'(image[pc]);
		end
		steps++;
	endtask

	task automatic take_write(word_t a, byte_t d);
		logic [23:0] e;
		if (exp_writes.size() == 0)
			fail_run($sformatf("unexpected write of %0h to address %0h", d, a));
		e = exp_writes.pop_front();
		check("write address", a, e[23:8]);
		check("write data", d, e[7:0]);
	endtask

	// byte addresses of the two bank write ports
	assign even_byte = {even_wr.addr, 1'b0};
	assign odd_byte = {odd_wr.addr, 1'b1};

	// write monitor takes the lower byte address first
	always @(negedge clk)
	begin
		if (checking)
		begin
			if (trap && (even_wr.en || odd_wr.en))
				fail_run("memory write seen while the core is trapped");
			if (odd_wr.en && (!even_wr.en || odd_byte < even_byte))
			begin
				take_write(odd_byte, odd_wr.data);
				if (even_wr.en)
					take_write(even_byte, even_wr.data);
			end
			else if (even_wr.en)
			begin
				take_write(even_byte, even_wr.data);
				if (odd_wr.en)
					take_write(odd_byte, odd_wr.data);
			end
		end
	end

	always @(negedge clk)
	begin
		if (armed)
		begin
			if (cycles_left == 0)
				fail_run("core never trapped before the watchdog ran out");
			cycles_left = cycles_left - 1;
		end
	end

	task automatic run_program(int prog);
		int steps;
		@(posedge clk);
		restart <= 1'b1;
		@(posedge clk);
		restart <= 1'b0;
		build_program();
		run_model(steps);
		$display("program %0d: %0d instructions, %0d byte writes", prog, steps,
			exp_writes.size());
		@(negedge clk);
		while (reset)
			@(negedge clk);
		check("even read address after reset", even_rd_addr, 32'h2000);
		check("odd read address after reset", odd_rd_addr, 32'h2000);
		check("write enables after reset", {even_wr.en, odd_wr.en}, 32'd0);
		check("trap after reset", trap, 32'd0);
		cycles_left = steps * 4 + 16;
		checking = 1'b1;
		armed = 1'b1;
		while (!trap)
			@(negedge clk);
		armed = 1'b0;
		repeat (8)
		begin
			@(negedge clk);
			check("trap held", trap, 32'd1);
		end
		check("expected writes left at trap", exp_writes.size(), 32'd0);
		checking = 1'b0;
	endtask

	initial
	begin
		word_t a;
		seed = 32;
		restart = 1'b0;
		checking = 1'b0;
		armed = 1'b0;
		cycles_left = 0;
		even_rd_data = 8'h00;
		odd_rd_data = 8'h00;
		// background pattern over the whole address
		for (int i = 0; i < 65536; i++)
		begin
			a = i[15:0];
			put_byte(a, a[15:8] ^ a[7:0] ^ 8'h3c);
		end
		for (int p = 0; p < 16; p++)
			run_program(p);
		$display("All checks passed");
		$finish;
	end

endmodule

//--- verilog/f8_alu.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 8-bit ALU for the accumulator. Purely combinational, with z/n/c flags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "f8_defines.svh"

module f8_alu import f8_pkg::*;
(
	input alu_op_t op,
	input byte_t a,
	input byte_t b,
	input flags_t flags_in,
	output byte_t result,
	output flags_t flags_out
);

	// one extra bit for the carry out
	logic [`F8_BYTE_W:0] sum;

	always_comb
	begin
		sum = '0;
		result = b;
		flags_out = flags_in;
		case (op)
			ALU_ADD:
			begin
				sum = {1'b0, a} + {1'b0, b};
				result = sum[`F8_BYTE_W-1:0];
				flags_out.c = sum[`F8_BYTE_W];
			end
			ALU_SUB:
			begin
				// a + ~b + 1 sets carry when nothing was borrowed
				sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
				result = sum[`F8_BYTE_W-1:0];
				flags_out.c = sum[`F8_BYTE_W];
			end
			ALU_AND:
				result = a & b;
			ALU_OR:
				result = a | b;
			ALU_XOR:
				result = a ^ b;
			default:
				result = b;
		endcase
		flags_out.z = (result == '0);
		flags_out.n = result[`F8_BYTE_W-1];
	end

endmodule

//--- verilog/f8_bank_port.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Even/odd bank steering, so any byte address reads or writes 16 bits
// in a single access, aligned or not.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module f8_bank_port import f8_pkg::*;
(
	input logic clk,
	input word_t rd_addr,
	output bank_addr_t even_rd_addr,
	output bank_addr_t odd_rd_addr,
	input byte_t even_rd_data,
	input byte_t odd_rd_data,
	output word_t rd_word,
	input mem_wr_t mem_wr,
	output bank_wr_t even_wr,
	output bank_wr_t odd_wr
);

	bank_addr_t rd_index;
	bank_addr_t wr_index;
	logic rd_odd_q;

	// odd start means the second byte sits in the next even word
	assign rd_index = rd_addr[15:1];
	assign odd_rd_addr = rd_index;
	assign even_rd_addr = rd_addr[0] ? rd_index + 1'b1 : rd_index;

	always_ff @(posedge clk)
		rd_odd_q <= rd_addr[0];

	assign rd_word = rd_odd_q ? {even_rd_data, odd_rd_data} : {odd_rd_data, even_rd_data};

	assign wr_index = mem_wr.addr[15:1];

	always_comb
	begin
		odd_wr.addr = wr_index;
		even_wr.addr = mem_wr.addr[0] ? wr_index + 1'b1 : wr_index;
		even_wr.data = mem_wr.addr[0] ? mem_wr.data[15:8] : mem_wr.data[7:0];
		odd_wr.data = mem_wr.addr[0] ? mem_wr.data[7:0] : mem_wr.data[15:8];
		even_wr.en = mem_wr.addr[0] ? mem_wr.en[1] : mem_wr.en[0];
		odd_wr.en = mem_wr.addr[0] ? mem_wr.en[0] : mem_wr.en[1];
	end

endmodule

//--- verilog/f8_core.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the multi-cycle f8 core. Connect to two byte-wide bank RAMs
// with one cycle of read latency; trap signals a halted core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module f8_core import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	output bank_addr_t even_rd_addr,
	input byte_t even_rd_data,
	output bank_wr_t even_wr,
	output bank_addr_t odd_rd_addr,
	input byte_t odd_rd_data,
	output bank_wr_t odd_wr,
	output logic trap
);

	word_t x;
	word_t y;
	word_t pc;
	word_t next_pc;
	word_t rd_addr;
	word_t rd_word;
	word_t operand;
	flags_t flags;
	flags_t next_flags;
	inst_t inst;
	reg_wr_t reg_wr;
	mem_wr_t mem_wr;
	logic execute;

	f8_regs i_regs
	(
		.clk(clk),
		.reset(reset),
		.reg_wr(reg_wr),
		.next_flags(next_flags),
		.next_pc(next_pc),
		.x(x),
		.y(y),
		.flags(flags),
		.pc(pc)
	);

	f8_bank_port i_bank_port
	(
		.clk(clk),
		.rd_addr(rd_addr),
		.even_rd_addr(even_rd_addr),
		.odd_rd_addr(odd_rd_addr),
		.even_rd_data(even_rd_data),
		.odd_rd_data(odd_rd_data),
		.rd_word(rd_word),
		.mem_wr(mem_wr),
		.even_wr(even_wr),
		.odd_wr(odd_wr)
	);

	f8_fetch i_fetch
	(
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.next_pc(next_pc),
		.rd_word(rd_word),
		.rd_addr(rd_addr),
		.inst(inst),
		.operand(operand),
		.execute(execute)
	);

	f8_exec i_exec
	(
		.execute(execute),
		.inst(inst),
		.operand(operand),
		.x(x),
		.y(y),
		.flags(flags),
		.pc(pc),
		.reg_wr(reg_wr),
		.next_flags(next_flags),
		.mem_wr(mem_wr),
		.next_pc(next_pc),
		.trap(trap)
	);

endmodule

//--- verilog/f8_defines.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Width and address constants shared by the f8 core and its package.
// Included by the package and by any module that sizes with them.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef F8_DEFINES_SVH
`define F8_DEFINES_SVH

// data and address widths
`define F8_BYTE_W 8
`define F8_WORD_W 16

// one bank holds every other byte
`define F8_BANK_AW 15

// longest instruction is opcode plus two bytes
`define F8_INST_BYTES 3
`define F8_INST_W (`F8_INST_BYTES * `F8_BYTE_W)

// first instruction after reset
`define F8_RESET_PC 16'h4000

`endif

//--- verilog/f8_exec.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Decode and execute. Turns one fetched instruction into register,
// flag and memory writes plus the next program counter.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module f8_exec import f8_pkg::*;
(
	input logic execute,
	input inst_t inst,
	input word_t operand,
	input word_t x,
	input word_t y,
	input flags_t flags,
	input word_t pc,
	output reg_wr_t reg_wr,
	output flags_t next_flags,
	output mem_wr_t mem_wr,
	output word_t next_pc,
	output logic trap
);

	opcode_t opcode;
	alu_op_t alu_op;
	byte_t alu_b;
	byte_t alu_result;
	flags_t alu_flags;
	word_t dir_word;
	word_t disp;
	logic taken;

	assign opcode = opcode_t'(inst[7:0]);
	// direct address or 16-bit immediate
	assign dir_word = inst[23:8];
	assign disp = {{8{inst[15]}}, inst[15:8]};
	assign trap = execute && opcode == OP_TRAP;

	always_comb
	begin
		alu_b = (opcode == OP_LD_XL_DIR) ? operand[7:0] : inst[15:8];
		case (opcode)
			OP_ADD_XL_IMMD: alu_op = ALU_ADD;
			OP_SUB_XL_IMMD: alu_op = ALU_SUB;
			OP_AND_XL_IMMD: alu_op = ALU_AND;
			OP_OR_XL_IMMD: alu_op = ALU_OR;
			OP_XOR_XL_IMMD: alu_op = ALU_XOR;
			default: alu_op = ALU_PASS;
		endcase
	end

	f8_alu i_alu
	(
		.op(alu_op),
		.a(x[7:0]),
		.b(alu_b),
		.flags_in(flags),
		.result(alu_result),
		.flags_out(alu_flags)
	);

	always_comb
	begin
		case (opcode)
			OP_JR_D: taken = 1'b1;
			OP_JRZ_D: taken = flags.z;
			OP_JRNZ_D: taken = !flags.z;
			OP_JRC_D: taken = flags.c;
			default: taken = 1'b0;
		endcase
	end

	always_comb
	begin
		reg_wr.sel = REG_X;
		reg_wr.data = {alu_result, alu_result};
		reg_wr.en = 2'b00;
		next_flags = flags;
		mem_wr.addr = dir_word;
		mem_wr.data = y;
		mem_wr.en = 2'b00;
		if (execute)
		begin
			case (opcode)
				OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD, OP_OR_XL_IMMD,
				OP_XOR_XL_IMMD, OP_LD_XL_IMMD, OP_LD_XL_DIR:
				begin
					reg_wr.en = 2'b01;
					next_flags = alu_flags;
				end
				OP_LD_DIR_XL:
				begin
					mem_wr.data = {8'h00, x[7:0]};
					mem_wr.en = 2'b01;
				end
				OP_LDW_Y_IMMD:
				begin
					reg_wr.sel = REG_Y;
					reg_wr.data = dir_word;
					reg_wr.en = 2'b11;
				end
				OP_LDW_DIR_Y:
					mem_wr.en = 2'b11;
				default:
					next_flags = flags;
			endcase
		end
	end

	// jumps are relative to their own address
	always_comb
	begin
		if (!execute || trap)
			next_pc = pc;
		else if (taken)
			next_pc = pc + disp;
		else
			next_pc = pc + {14'd0, opcode_size(opcode)};
	end

endmodule

//--- verilog/f8_fetch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Fetch sequencer. Collects opcode, upper byte and memory operand from
// the banks and flags the one cycle in which the instruction executes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module f8_fetch import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input word_t pc,
	input word_t next_pc,
	input word_t rd_word,
	output word_t rd_addr,
	output inst_t inst,
	output word_t operand,
	output logic execute
);

	fetch_state_t state;
	fetch_state_t state_nxt;
	inst_t held;
	// low until the bank data matches pc
	logic primed;

	// operand read only matters in FETCH_OPERAND
	assign operand = rd_word;

	always_comb
	begin
		inst = held;
		execute = 1'b0;
		rd_addr = next_pc;
		state_nxt = state;
		case (state)
			FETCH_OPCODE:
			begin
				if (primed)
				begin
					inst = {8'h00, rd_word};
					if (opcode_size(opcode_t'(rd_word[7:0])) == 2'd3)
					begin
						rd_addr = pc + 16'd2;
						state_nxt = FETCH_UPPER;
					end
					else
						execute = 1'b1;
				end
			end
			FETCH_UPPER:
			begin
				inst = {rd_word[7:0], held[15:0]};
				if (opcode_reads_mem(opcode_t'(held[7:0])))
				begin
					// direct address is the two bytes after the opcode
					rd_addr = {rd_word[7:0], held[15:8]};
					state_nxt = FETCH_OPERAND;
				end
				else
				begin
					execute = 1'b1;
					state_nxt = FETCH_OPCODE;
				end
			end
			FETCH_OPERAND:
			begin
				execute = 1'b1;
				state_nxt = FETCH_OPCODE;
			end
			default:
				state_nxt = FETCH_OPCODE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= FETCH_OPCODE;
			held <= inst_t'(OP_NOP);
			primed <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			held <= inst;
			primed <= 1'b1;
		end
	end

endmodule

//--- verilog/f8_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Types, opcode encodings and decode helpers for the f8 core.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "f8_defines.svh"

package f8_pkg;

	typedef logic [`F8_BYTE_W-1:0] byte_t;
	typedef logic [`F8_WORD_W-1:0] word_t;
	typedef logic [`F8_BANK_AW-1:0] bank_addr_t;
	// opcode in the low byte
	typedef logic [`F8_INST_W-1:0] inst_t;

	// zero bytes trap, so a run into blank memory halts
	typedef enum logic [7:0]
	{
		OP_TRAP        = 8'h00,
		OP_NOP         = 8'h08,
		OP_SUB_XL_IMMD = 8'h10,
		OP_ADD_XL_IMMD = 8'h18,
		OP_OR_XL_IMMD  = 8'h28,
		OP_AND_XL_IMMD = 8'h30,
		OP_XOR_XL_IMMD = 8'h38,
		OP_LD_XL_IMMD  = 8'h90,
		OP_LD_XL_DIR   = 8'h91,
		OP_LD_DIR_XL   = 8'h98,
		OP_LDW_Y_IMMD  = 8'hb0,
		OP_LDW_DIR_Y   = 8'hb8,
		OP_JR_D        = 8'hd0,
		OP_JRZ_D       = 8'hd1,
		OP_JRNZ_D      = 8'hd2,
		OP_JRC_D       = 8'hd3
	} opcode_t;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_PASS} alu_op_t;

	typedef enum logic [1:0] {FETCH_OPCODE, FETCH_UPPER, FETCH_OPERAND} fetch_state_t;

	typedef enum logic {REG_X, REG_Y} reg_sel_t;

	typedef struct packed
	{
		logic z;
		logic n;
		logic c;
	} flags_t;

	typedef struct packed
	{
		reg_sel_t sel;
		word_t data;
		logic [1:0] en;
	} reg_wr_t;

	// en[0] is the byte at addr, en[1] the byte after it
	typedef struct packed
	{
		word_t addr;
		word_t data;
		logic [1:0] en;
	} mem_wr_t;

	typedef struct packed
	{
		bank_addr_t addr;
		byte_t data;
		logic en;
	} bank_wr_t;

	function automatic logic [1:0] opcode_size(opcode_t op);
		case (op)
			OP_LD_XL_DIR, OP_LD_DIR_XL, OP_LDW_Y_IMMD, OP_LDW_DIR_Y:
				return 2'd3;
			OP_LD_XL_IMMD, OP_ADD_XL_IMMD, OP_SUB_XL_IMMD, OP_AND_XL_IMMD, OP_OR_XL_IMMD,
			OP_XOR_XL_IMMD, OP_JR_D, OP_JRZ_D, OP_JRNZ_D, OP_JRC_D:
				return 2'd2;
			default:
				return 2'd1;
		endcase
	endfunction

	function automatic logic opcode_reads_mem(opcode_t op);
		return op == OP_LD_XL_DIR;
	endfunction

endpackage

//--- verilog/f8_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Architectural state of the f8 core: x, y, flags and program counter.
// All updates come from the execute stage and land at the clock edge.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

`include "f8_defines.svh"

module f8_regs import f8_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_wr_t reg_wr,
	input flags_t next_flags,
	input word_t next_pc,
	output word_t x,
	output word_t y,
	output flags_t flags,
	output word_t pc
);

	// byte-enabled register writes
	always_ff @(posedge clk)
	begin
		if (reg_wr.sel == REG_X)
		begin
			if (reg_wr.en[0])
				x[7:0] <= reg_wr.data[7:0];
			if (reg_wr.en[1])
				x[15:8] <= reg_wr.data[15:8];
		end
		else
		begin
			if (reg_wr.en[0])
				y[7:0] <= reg_wr.data[7:0];
			if (reg_wr.en[1])
				y[15:8] <= reg_wr.data[15:8];
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc <= `F8_RESET_PC;
			flags <= '0;
		end
		else
		begin
			pc <= next_pc;
			flags <= next_flags;
		end
	end

endmodule

//--- vlog.f
+incdir+verilog
verilog/f8_pkg.sv
verilog/f8_regs.sv
verilog/f8_fetch.sv
verilog/f8_alu.sv
verilog/f8_exec.sv
verilog/f8_bank_port.sv
verilog/f8_core.sv
sim/tb_clock.sv
sim/tb_f8_core.sv
